// File: common/tile_pkg.sv
// Shared definitions for the tile scaler
//   default element width and tile dimensions
//   configuration register selector
package tile_pkg;

  // Default element width in bits
  parameter int DATA_WIDTH = 16;

  // Default tile dimensions, rows by columns
  parameter int ROWS = 4;
  parameter int COLS = 4;

  // Selects which configuration register a host write lands in
  typedef enum logic [0:0] {
    CFG_SCALE = 1'b0,
    CFG_BIAS  = 1'b1
  } cfg_sel_t;

endpackage

// File: common/mem_port_if.sv
`timescale 1ns/1ps
// One sequential memory port
//   address, read and write strobes, write data
//   read data and done pulses back from the memory
//   requester and memory modports
interface mem_port_if #(
  parameter int WIDTH  = 16,
  parameter int ADDR_W = 4
) ();

  // Request side
  logic [ADDR_W-1:0] addr;
  logic              read_en;
  logic              write_en;
  logic [WIDTH-1:0]  wdata;

  // Response side, one cycle after the strobe
  logic [WIDTH-1:0]  rdata;
  logic              read_done;
  logic              write_done;

  modport requester (
    output addr,
    output read_en,
    output write_en,
    output wdata,
    input  rdata,
    input  read_done,
    input  write_done
  );

  modport memory (
    input  addr,
    input  read_en,
    input  write_en,
    input  wdata,
    output rdata,
    output read_done,
    output write_done
  );

endinterface

// File: mem/seq_mem_d1.sv
`timescale 1ns/1ps
// Flat sequential memory
//   one-cycle reads and writes
//   read data held until the next read, unknown after a write
//   registered read and write done pulses
module seq_mem_d1 #(
  parameter int WIDTH = 16,
  parameter int SIZE  = 16
) (
  input logic        clk,
  input logic        reset,
  mem_port_if.memory port
);

  // Storage array
  logic [WIDTH-1:0] mem [SIZE];

  // Write path
  always_ff @(posedge clk) begin
    if (port.write_en) begin
      mem[port.addr] <= port.wdata;
    end
  end

  // Registered read output
  always_ff @(posedge clk) begin
    if (reset) begin
      port.rdata <= '0;
    end else if (port.read_en) begin
      port.rdata <= mem[port.addr];
    end else if (port.write_en) begin
      // Read data is not valid past a write
      port.rdata <= 'x;
    end
  end

  // Done pulses follow their strobe by one cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      port.read_done  <= 1'b0;
      port.write_done <= 1'b0;
    end else begin
      port.read_done  <= port.read_en;
      port.write_done <= port.write_en;
    end
  end

endmodule

// File: mem/seq_mem_d2.sv
`timescale 1ns/1ps
// Two-dimensional sequential memory
//   splits the port address into row and column fields
//   maps them to a flat index over the flat memory
module seq_mem_d2 #(
  parameter int WIDTH   = 16,
  parameter int D0_SIZE = 4,
  parameter int D1_SIZE = 4
) (
  input logic        clk,
  input logic        reset,
  mem_port_if.memory port
);

  localparam int ROW_W = (D0_SIZE > 1) ? $clog2(D0_SIZE) : 1;
  localparam int COL_W = (D1_SIZE > 1) ? $clog2(D1_SIZE) : 1;
  localparam int SIZE  = D0_SIZE * D1_SIZE;
  localparam int IDX_W = (SIZE > 1) ? $clog2(SIZE) : 1;

  logic [ROW_W-1:0] row;
  logic [COL_W-1:0] col;

  mem_port_if #(.WIDTH(WIDTH), .ADDR_W(IDX_W)) flat_port ();

  // Row sits above the column in the address
  assign row = port.addr[COL_W +: ROW_W];
  assign col = port.addr[COL_W-1:0];

  // Row-major flat index
  assign flat_port.addr = IDX_W'(row) * IDX_W'(D1_SIZE) + IDX_W'(col);

  assign flat_port.read_en  = port.read_en;
  assign flat_port.write_en = port.write_en;
  assign flat_port.wdata    = port.wdata;

  assign port.rdata      = flat_port.rdata;
  assign port.read_done  = flat_port.read_done;
  assign port.write_done = flat_port.write_done;

  seq_mem_d1 #(
    .WIDTH (WIDTH),
    .SIZE  (SIZE)
  ) flat_mem (
    .clk   (clk),
    .reset (reset),
    .port  (flat_port)
  );

endmodule

// File: source/scale_regs.sv
`timescale 1ns/1ps
// Configuration registers
//   scale and bias, written by the host through a selector
module scale_regs #(
  parameter int WIDTH = 16
) (
  input  logic               clk,
  input  logic               reset,
  input  logic               cfg_we,
  input  tile_pkg::cfg_sel_t cfg_sel,
  input  logic [WIDTH-1:0]   cfg_data,
  output logic [WIDTH-1:0]   scale,
  output logic [WIDTH-1:0]   bias
);

  // Scale register
  always_ff @(posedge clk) begin
    if (reset) begin
      scale <= '0;
    end else if (cfg_we && cfg_sel == tile_pkg::CFG_SCALE) begin
      scale <= cfg_data;
    end
  end

  // Bias register
  always_ff @(posedge clk) begin
    if (reset) begin
      bias <= '0;
    end else if (cfg_we && cfg_sel == tile_pkg::CFG_BIAS) begin
      bias <= cfg_data;
    end
  end

endmodule

// File: source/scale_ctrl.sv
`timescale 1ns/1ps
// Tile walk controller
//   row and column counters over the input tile
//   read, scale and bias, write to the transposed index
//   busy level and one-cycle done pulse
module scale_ctrl #(
  parameter int WIDTH   = 16,
  parameter int D0_SIZE = 4,
  parameter int D1_SIZE = 4
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 start,
  input  logic [WIDTH-1:0]     scale,
  input  logic [WIDTH-1:0]     bias,
  output logic                 busy,
  output logic                 done,
  mem_port_if.requester        in_port,
  mem_port_if.requester        out_port
);

  localparam int ROW_W  = (D0_SIZE > 1) ? $clog2(D0_SIZE) : 1;
  localparam int COL_W  = (D1_SIZE > 1) ? $clog2(D1_SIZE) : 1;
  localparam int OUT_AW = (D0_SIZE * D1_SIZE > 1) ? $clog2(D0_SIZE * D1_SIZE) : 1;

  typedef enum logic [2:0] {
    S_IDLE,
    S_READ,
    S_RWAIT,
    S_WRITE,
    S_WWAIT
  } state_t;

  state_t           state;
  logic [ROW_W-1:0] row;
  logic [COL_W-1:0] col;
  logic [WIDTH-1:0] scaled;
  logic [WIDTH-1:0] result;
  logic             last_row;
  logic             last_col;

  // Truncates to WIDTH bits, which is the intended wrap
  assign scaled = in_port.rdata * scale + bias;

  assign last_row = (row == ROW_W'(D0_SIZE - 1));
  assign last_col = (col == COL_W'(D1_SIZE - 1));

  assign busy = (state != S_IDLE);

  // Input side reads only, row above column
  assign in_port.addr     = {row, col};
  assign in_port.read_en  = (state == S_READ);
  assign in_port.write_en = 1'b0;
  assign in_port.wdata    = '0;

  // Output side writes only, at column * rows + row
  assign out_port.addr     = OUT_AW'(col) * OUT_AW'(D0_SIZE) + OUT_AW'(row);
  assign out_port.read_en  = 1'b0;
  assign out_port.write_en = (state == S_WRITE);
  assign out_port.wdata    = result;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= S_IDLE;
      row   <= '0;
      col   <= '0;
      done  <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        S_IDLE: begin
          if (start) begin
            row   <= '0;
            col   <= '0;
            state <= S_READ;
          end
        end
        S_READ: begin
          state <= S_RWAIT;
        end
        S_RWAIT: begin
          if (in_port.read_done) begin
            state <= S_WRITE;
          end
        end
        S_WRITE: begin
          state <= S_WWAIT;
        end
        S_WWAIT: begin
          if (out_port.write_done) begin
            if (last_row && last_col) begin
              // Whole tile written
              done  <= 1'b1;
              row   <= '0;
              col   <= '0;
              state <= S_IDLE;
            end else if (last_col) begin
              col   <= '0;
              row   <= row + 1'b1;
              state <= S_READ;
            end else begin
              col   <= col + 1'b1;
              state <= S_READ;
            end
          end
        end
        default: begin
          state <= S_IDLE;
        end
      endcase
    end
  end

  // Scaled value captured with the read data
  always_ff @(posedge clk) begin
    if (state == S_RWAIT && in_port.read_done) begin
      result <= scaled;
    end
  end

endmodule

// File: source/mem_host_arb.sv
`timescale 1ns/1ps
// Memory port routing
//   controller ports while busy
//   host write to the input memory and host read from the output memory while idle
module mem_host_arb #(
  parameter int   WIDTH   = 16,
  parameter int   D0_SIZE = 4,
  parameter int   D1_SIZE = 4,
  localparam int ROW_W  = (D0_SIZE > 1) ? $clog2(D0_SIZE) : 1,
  localparam int COL_W  = (D1_SIZE > 1) ? $clog2(D1_SIZE) : 1,
  localparam int OUT_AW = (D0_SIZE * D1_SIZE > 1) ? $clog2(D0_SIZE * D1_SIZE) : 1
) (
  input  logic              busy,
  input  logic              host_wr_en,
  input  logic [ROW_W-1:0]  host_wr_row,
  input  logic [COL_W-1:0]  host_wr_col,
  input  logic [WIDTH-1:0]  host_wr_data,
  input  logic              host_rd_en,
  input  logic [OUT_AW-1:0] host_rd_addr,
  output logic [WIDTH-1:0]  host_rd_data,
  output logic              host_rd_valid,
  mem_port_if.memory        ctrl_in,
  mem_port_if.memory        ctrl_out,
  mem_port_if.requester     in_mem,
  mem_port_if.requester     out_mem
);

  // Input memory request mux
  always_comb begin
    if (busy) begin
      in_mem.addr     = ctrl_in.addr;
      in_mem.read_en  = ctrl_in.read_en;
      in_mem.write_en = ctrl_in.write_en;
      in_mem.wdata    = ctrl_in.wdata;
    end else begin
      in_mem.addr     = {host_wr_row, host_wr_col};
      in_mem.read_en  = 1'b0;
      in_mem.write_en = host_wr_en;
      in_mem.wdata    = host_wr_data;
    end
  end

  // Output memory request mux
  always_comb begin
    if (busy) begin
      out_mem.addr     = ctrl_out.addr;
      out_mem.read_en  = ctrl_out.read_en;
      out_mem.write_en = ctrl_out.write_en;
      out_mem.wdata    = ctrl_out.wdata;
    end else begin
      out_mem.addr     = host_rd_addr;
      out_mem.read_en  = host_rd_en;
      out_mem.write_en = 1'b0;
      out_mem.wdata    = '0;
    end
  end

  // Responses go back to the controller unconditionally
  assign ctrl_in.rdata       = in_mem.rdata;
  assign ctrl_in.read_done   = in_mem.read_done;
  assign ctrl_in.write_done  = in_mem.write_done;
  assign ctrl_out.rdata      = out_mem.rdata;
  assign ctrl_out.read_done  = out_mem.read_done;
  assign ctrl_out.write_done = out_mem.write_done;

  // Only the host ever reads the output memory
  assign host_rd_data  = out_mem.rdata;
  assign host_rd_valid = out_mem.read_done;

endmodule

// File: source/tile_scaler.sv
`timescale 1ns/1ps
// Tile scale and transpose accelerator, top level
//   input tile memory, flat output memory
//   configuration registers, walk controller, host routing
module tile_scaler #(
  parameter int   WIDTH   = tile_pkg::DATA_WIDTH,
  parameter int   D0_SIZE = tile_pkg::ROWS,
  parameter int   D1_SIZE = tile_pkg::COLS,
  localparam int ROW_W  = (D0_SIZE > 1) ? $clog2(D0_SIZE) : 1,
  localparam int COL_W  = (D1_SIZE > 1) ? $clog2(D1_SIZE) : 1,
  localparam int OUT_AW = (D0_SIZE * D1_SIZE > 1) ? $clog2(D0_SIZE * D1_SIZE) : 1
) (
  input  logic               clk,
  input  logic               reset,
  input  logic               host_wr_en,
  input  logic [ROW_W-1:0]   host_wr_row,
  input  logic [COL_W-1:0]   host_wr_col,
  input  logic [WIDTH-1:0]   host_wr_data,
  input  logic               host_rd_en,
  input  logic [OUT_AW-1:0]  host_rd_addr,
  output logic [WIDTH-1:0]   host_rd_data,
  output logic               host_rd_valid,
  input  logic               cfg_we,
  input  tile_pkg::cfg_sel_t cfg_sel,
  input  logic [WIDTH-1:0]   cfg_data,
  input  logic               start,
  output logic               busy,
  output logic               done
);

  localparam int IN_AW = ROW_W + COL_W;

  logic [WIDTH-1:0] scale;
  logic [WIDTH-1:0] bias;

  mem_port_if #(.WIDTH(WIDTH), .ADDR_W(IN_AW))  ctrl_in_port ();
  mem_port_if #(.WIDTH(WIDTH), .ADDR_W(OUT_AW)) ctrl_out_port ();
  mem_port_if #(.WIDTH(WIDTH), .ADDR_W(IN_AW))  in_mem_port ();
  mem_port_if #(.WIDTH(WIDTH), .ADDR_W(OUT_AW)) out_mem_port ();

  scale_regs #(
    .WIDTH (WIDTH)
  ) regs (
    .clk      (clk),
    .reset    (reset),
    .cfg_we   (cfg_we),
    .cfg_sel  (cfg_sel),
    .cfg_data (cfg_data),
    .scale    (scale),
    .bias     (bias)
  );

  scale_ctrl #(
    .WIDTH   (WIDTH),
    .D0_SIZE (D0_SIZE),
    .D1_SIZE (D1_SIZE)
  ) ctrl (
    .clk      (clk),
    .reset    (reset),
    .start    (start),
    .scale    (scale),
    .bias     (bias),
    .busy     (busy),
    .done     (done),
    .in_port  (ctrl_in_port),
    .out_port (ctrl_out_port)
  );

  mem_host_arb #(
    .WIDTH   (WIDTH),
    .D0_SIZE (D0_SIZE),
    .D1_SIZE (D1_SIZE)
  ) arb (
    .busy          (busy),
    .host_wr_en    (host_wr_en),
    .host_wr_row   (host_wr_row),
    .host_wr_col   (host_wr_col),
    .host_wr_data  (host_wr_data),
    .host_rd_en    (host_rd_en),
    .host_rd_addr  (host_rd_addr),
    .host_rd_data  (host_rd_data),
    .host_rd_valid (host_rd_valid),
    .ctrl_in       (ctrl_in_port),
    .ctrl_out      (ctrl_out_port),
    .in_mem        (in_mem_port),
    .out_mem       (out_mem_port)
  );

  // Input tile, addressed by row and column
  seq_mem_d2 #(
    .WIDTH   (WIDTH),
    .D0_SIZE (D0_SIZE),
    .D1_SIZE (D1_SIZE)
  ) in_mem (
    .clk   (clk),
    .reset (reset),
    .port  (in_mem_port)
  );

  // Transposed results, flat
  seq_mem_d1 #(
    .WIDTH (WIDTH),
    .SIZE  (D0_SIZE * D1_SIZE)
  ) out_mem (
    .clk   (clk),
    .reset (reset),
    .port  (out_mem_port)
  );

endmodule

// File: bench/tb_clock.sv
`timescale 1ns/1ps
// Testbench clock generator
//   free-running clock with a configurable period
module tb_clock #(
  parameter int PERIOD = 20
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  always begin
    #(PERIOD / 2) clk = ~clk;
  end

endmodule

// File: bench/tile_scaler_tb.sv
`timescale 1ns/1ps
// Testbench for the tile scaler
//   table of scale, bias and fill cases applied in a loop
//   reference model of the scale and transpose rule
//   run length, handshake and read-back checks with a cycle limit
module tile_scaler_tb;

  localparam int W      = tile_pkg::DATA_WIDTH;
  localparam int ROWS   = tile_pkg::ROWS;
  localparam int COLS   = tile_pkg::COLS;
  localparam int N      = ROWS * COLS;
  localparam int ROW_W  = (ROWS > 1) ? $clog2(ROWS) : 1;
  localparam int COL_W  = (COLS > 1) ? $clog2(COLS) : 1;
  localparam int OUT_AW = (N > 1) ? $clog2(N) : 1;

  localparam int FILL_RANDOM = 0;
  localparam int FILL_ONES   = 1;
  localparam int FILL_INDEX  = 2;

  localparam int NUM_CASES       = 5;
  localparam int LOAD_CYCLES     = N + 8;
  localparam int RUN_CYCLES      = 4 * N + 1;
  localparam int READBACK_CYCLES = 3 * N;
  localparam int CYCLE_LIMIT     =
    NUM_CASES * (LOAD_CYCLES + RUN_CYCLES + 2 + READBACK_CYCLES) + 60;

  logic               clk;
  logic               reset;
  logic               host_wr_en;
  logic [ROW_W-1:0]   host_wr_row;
  logic [COL_W-1:0]   host_wr_col;
  logic [W-1:0]       host_wr_data;
  logic               host_rd_en;
  logic [OUT_AW-1:0]  host_rd_addr;
  logic [W-1:0]       host_rd_data;
  logic               host_rd_valid;
  logic               cfg_we;
  tile_pkg::cfg_sel_t cfg_sel;
  logic [W-1:0]       cfg_data;
  logic               start;
  logic               busy;
  logic               done;

  // Case table
  string        case_name  [NUM_CASES];
  logic [W-1:0] case_scale [NUM_CASES];
  logic [W-1:0] case_bias  [NUM_CASES];
  int           case_fill  [NUM_CASES];

  logic [W-1:0] tile [ROWS][COLS];
  logic [W-1:0] expect_out [N];
  int           errors;
  int           checks;
  int           cycle_count;

  tb_clock #(.PERIOD(20)) clock_gen (.clk(clk));

  tile_scaler uut (
    .clk           (clk),
    .reset         (reset),
    .host_wr_en    (host_wr_en),
    .host_wr_row   (host_wr_row),
    .host_wr_col   (host_wr_col),
    .host_wr_data  (host_wr_data),
    .host_rd_en    (host_rd_en),
    .host_rd_addr  (host_rd_addr),
    .host_rd_data  (host_rd_data),
    .host_rd_valid (host_rd_valid),
    .cfg_we        (cfg_we),
    .cfg_sel       (cfg_sel),
    .cfg_data      (cfg_data),
    .start         (start),
    .busy          (busy),
    .done          (done)
  );

  // Run limit
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Regression failed");
      $finish;
    end
  end

  task automatic report_value(input string name, input logic [W-1:0] exp,
                              input logic [W-1:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERR %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic write_cfg(input tile_pkg::cfg_sel_t sel, input logic [W-1:0] data);
    @(negedge clk);
    cfg_we   = 1'b1;
    cfg_sel  = sel;
    cfg_data = data;
    @(negedge clk);
    cfg_we   = 1'b0;
  endtask

  task automatic fill_tile(input int mode);
    for (int r = 0; r < ROWS; r++) begin
      for (int c = 0; c < COLS; c++) begin
        case (mode)
          FILL_RANDOM: tile[r][c] = W'($urandom);
          FILL_ONES:   tile[r][c] = '1;
          default:     tile[r][c] = W'(r * COLS + c);
        endcase
      end
    end
  endtask

  task automatic load_tile();
    for (int r = 0; r < ROWS; r++) begin
      for (int c = 0; c < COLS; c++) begin
        @(negedge clk);
        host_wr_en   = 1'b1;
        host_wr_row  = ROW_W'(r);
        host_wr_col  = COL_W'(c);
        host_wr_data = tile[r][c];
      end
    end
    @(negedge clk);
    host_wr_en = 1'b0;
  endtask

  // Transposed placement with a wrap to W bits
  task automatic build_model(input logic [W-1:0] sc, input logic [W-1:0] bs);
    logic [2*W-1:0] full;
    for (int r = 0; r < ROWS; r++) begin
      for (int c = 0; c < COLS; c++) begin
        full = {{W{1'b0}}, tile[r][c]} * {{W{1'b0}}, sc} + {{W{1'b0}}, bs};
        expect_out[c * ROWS + r] = full[W-1:0];
      end
    end
  endtask

  // Second start and a host write land in the middle of the run
  // The write targets the last element, which is still unread then
  task automatic run_tile(input string name);
    int cycles;
    bit ended;
    cycles = 0;
    ended  = 1'b0;
    @(negedge clk);
    start        = 1'b1;
    host_wr_row  = ROW_W'(ROWS - 1);
    host_wr_col  = COL_W'(COLS - 1);
    host_wr_data = ~tile[ROWS-1][COLS-1];
    while (!ended) begin
      @(negedge clk);
      cycles++;
      start      = (cycles == 10);
      host_wr_en = (cycles == 20);
      if (done) begin
        ended = 1'b1;
        report_value({name, " run length"}, W'(RUN_CYCLES), W'(cycles));
        report_value({name, " busy at done"}, '0, W'(busy));
      end else if (!busy) begin
        ended = 1'b1;
        errors++;
        $display("%s: busy went low after %0d cycles without done", name, cycles);
      end
    end
    start      = 1'b0;
    host_wr_en = 1'b0;
    @(negedge clk);
    report_value({name, " done width"}, '0, W'(done));
  endtask

  task automatic read_check(input string name, input int addr);
    logic [W-1:0] got;
    @(negedge clk);
    host_rd_en   = 1'b1;
    host_rd_addr = OUT_AW'(addr);
    @(negedge clk);
    host_rd_en = 1'b0;
    got        = host_rd_data;
    report_value($sformatf("%s valid[%0d]", name, addr), W'(1), W'(host_rd_valid));
    report_value($sformatf("%s out[%0d]", name, addr), expect_out[addr], got);
    @(negedge clk);
    report_value($sformatf("%s valid drop[%0d]", name, addr), '0, W'(host_rd_valid));
    report_value($sformatf("%s hold[%0d]", name, addr), got, host_rd_data);
  endtask

  initial begin
    void'($urandom(32'ha68a5bc5));
    errors       = 0;
    checks       = 0;
    cycle_count  = 0;
    reset        = 1'b1;
    host_wr_en   = 1'b0;
    host_wr_row  = '0;
    host_wr_col  = '0;
    host_wr_data = '0;
    host_rd_en   = 1'b0;
    host_rd_addr = '0;
    cfg_we       = 1'b0;
    cfg_sel      = tile_pkg::CFG_SCALE;
    cfg_data     = '0;
    start        = 1'b0;

    case_name[0]  = "rand_basic";
    case_scale[0] = 16'h0003;
    case_bias[0]  = 16'h0005;
    case_fill[0]  = FILL_RANDOM;
    case_name[1]  = "ones_wrap";
    case_scale[1] = 16'hffff;
    case_bias[1]  = 16'h0002;
    case_fill[1]  = FILL_ONES;
    case_name[2]  = "index_val";
    case_scale[2] = 16'h0101;
    case_bias[2]  = 16'h8000;
    case_fill[2]  = FILL_INDEX;
    case_name[3]  = "rand_large";
    case_scale[3] = 16'h7fff;
    case_bias[3]  = 16'hffff;
    case_fill[3]  = FILL_RANDOM;
    case_name[4]  = "bias_only";
    case_scale[4] = 16'h0000;
    case_bias[4]  = 16'h1234;
    case_fill[4]  = FILL_RANDOM;

    repeat (3) @(negedge clk);
    reset = 1'b0;

    // Idle state straight out of reset
    @(negedge clk);
    report_value("reset busy", '0, W'(busy));
    report_value("reset done", '0, W'(done));
    report_value("reset rd_valid", '0, W'(host_rd_valid));
    report_value("reset rd_data", '0, host_rd_data);

    for (int i = 0; i < NUM_CASES; i++) begin
      write_cfg(tile_pkg::CFG_SCALE, case_scale[i]);
      write_cfg(tile_pkg::CFG_BIAS, case_bias[i]);
      fill_tile(case_fill[i]);
      load_tile();
      build_model(case_scale[i], case_bias[i]);
      run_tile(case_name[i]);
      for (int a = 0; a < N; a++) begin
        read_check(case_name[i], a);
      end
    end

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// File: tile_scaler.f
common/tile_pkg.sv
common/mem_port_if.sv
mem/seq_mem_d1.sv
mem/seq_mem_d2.sv
source/scale_regs.sv
source/scale_ctrl.sv
source/mem_host_arb.sv
source/tile_scaler.sv
bench/tb_clock.sv
bench/tile_scaler_tb.sv
